/* Makefile */
BIN := obj_dir/Vcalculator_tb

.PHONY: compile run clean

compile:
	verilator --binary --assert --top-module calculator_tb -f calculator_top.f

run: compile
	$(BIN) > sim.log 2>&1; status=$$?; cat sim.log; \
	if grep -q "=== FAIL ===" sim.log; then exit 1; fi; exit $$status

clean:
	rm -rf obj_dir sim.log

/* calculator_top.f */
logic/calc_pkg.sv
logic/calc_decode.sv
logic/calc_bypass.sv
logic/calc_pipe_int.sv
logic/calc_pipe_mul.sv
logic/calc_completion.sv
logic/calculator_top.sv
dv/tb_clock.sv
dv/calculator_tb.sv

/* dv/calculator_tb.sv */
`timescale 1ns/1ps

module calculator_tb;

  import calc_pkg::*;

  localparam int planned_instr_lp = 246;
  localparam int hist_els_lp      = 4096;

  logic        clk, reset;
  logic        flush, dispatch_v;
  calc_instr_u dispatch_instr;
  logic [31:0] dispatch_rs1, dispatch_rs2;
  logic        commit_v, commit_illegal, wb_v;
  calc_instr_u commit_instr;
  logic [4:0]  wb_rd_addr;
  logic [31:0] wb_data;

  int          cyc, errors, dispatched;
  logic [31:0] arch_rf [32];
  logic [31:0] stale_rf [32];
  int          due_q [$];
  logic [4:0]  rd_q [$];
  logic [31:0] val_q [$];
  bit          exp_c_v [hist_els_lp];
  bit          exp_c_ill [hist_els_lp];
  logic [31:0] exp_c_instr [hist_els_lp];
  bit          exp_w_v [hist_els_lp];
  logic [4:0]  exp_w_rd [hist_els_lp];
  logic [31:0] exp_w_data [hist_els_lp];
  logic [31:0] lcg_state;
  bit          prev_mul;

  tb_clock clock_gen
    (.clk_o(clk)
    ,.reset_o(reset)
    );

  calculator_top UUT
    (.clk_i(clk)
    ,.reset_i(reset)
    ,.flush_i(flush)
    ,.dispatch_v_i(dispatch_v)
    ,.dispatch_instr_i(dispatch_instr)
    ,.dispatch_rs1_i(dispatch_rs1)
    ,.dispatch_rs2_i(dispatch_rs2)
    ,.commit_v_o(commit_v)
    ,.commit_instr_o(commit_instr)
    ,.commit_illegal_o(commit_illegal)
    ,.wb_v_o(wb_v)
    ,.wb_rd_addr_o(wb_rd_addr)
    ,.wb_data_o(wb_data)
    );

  always @(posedge clk)
    begin
      cyc <= cyc + 1;
    end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic [31:0] rtype_word(input logic [6:0] f7, input logic [4:0] rs2,
                                              input logic [4:0] rs1, input logic [2:0] f3,
                                              input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] itype_word(input logic [11:0] imm, input logic [4:0] rs1,
                                              input logic [2:0] f3, input logic [4:0] rd);
    return {imm, rs1, f3, rd, 7'b0010011};
  endfunction

  function automatic bit legal_instr(input logic [31:0] w);
    if (w[6:0] == 7'b0110011)
      return (w[31:25] == 7'h00 && w[14:12] != 3'b011)
          || (w[31:25] == 7'h20 && w[14:12] == 3'b000)
          || (w[31:25] == 7'h01 && w[14:12] == 3'b000);
    if (w[6:0] == 7'b0010011)
      return w[14:12] inside {3'b000, 3'b010, 3'b100, 3'b110, 3'b111};
    return 1'b0;
  endfunction

  // Architectural result of a legal instruction
  function automatic logic [31:0] model_result(input logic [31:0] w, input logic [31:0] a,
                                               input logic [31:0] rb);
    logic [31:0] b;
    b = (w[6:0] == 7'b0010011) ? {{20{w[31]}}, w[31:20]} : rb;
    if (w[6:0] == 7'b0110011 && w[31:25] == 7'h01)
      return a * b;
    case (w[14:12])
      3'b000: return (w[6:0] == 7'b0110011 && w[30]) ? a - b : a + b;
      3'b001: return a << b[4:0];
      3'b010: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'b100: return a ^ b;
      3'b101: return a >> b[4:0];
      3'b110: return a | b;
      default: return a & b;
    endcase
  endfunction

  // Register file the issuer reads, updated when a writeback cycle ends
  task automatic apply_due_writes(input int edge_n);
    while (due_q.size() > 0 && due_q[0] <= edge_n)
      begin
        stale_rf[rd_q[0]] = val_q[0];
        void'(due_q.pop_front());
        void'(rd_q.pop_front());
        void'(val_q.pop_front());
      end
  endtask

  task automatic send(input logic [31:0] w, input bit killed, input bit flush_now);
    int          e0;
    logic [4:0]  rs1, rs2, rd;
    logic [31:0] res;
    bit          legal;
    @(posedge clk);
    apply_due_writes(cyc);
    e0 = cyc + 2;
    rs1 = w[19:15];
    rs2 = w[24:20];
    rd = w[11:7];
    legal = legal_instr(w);
    dispatch_v <= 1'b1;
    dispatch_instr <= w;
    dispatch_rs1 <= stale_rf[rs1];
    dispatch_rs2 <= stale_rf[rs2];
    flush <= flush_now;
    dispatched++;
    prev_mul = legal && w[6:0] == 7'b0110011 && w[31:25] == 7'h01;
    if (!killed)
      begin
        exp_c_v[e0+2] = 1'b1;
        exp_c_ill[e0+2] = !legal;
        exp_c_instr[e0+2] = w;
        if (legal && rd != 5'd0)
          begin
            res = model_result(w, arch_rf[rs1], arch_rf[rs2]);
            exp_w_v[e0+3] = 1'b1;
            exp_w_rd[e0+3] = rd;
            exp_w_data[e0+3] = res;
            arch_rf[rd] = res;
            due_q.push_back(e0 + 4);
            rd_q.push_back(rd);
            val_q.push_back(res);
          end
      end
  endtask

  task automatic bubble(input bit flush_now);
    @(posedge clk);
    apply_due_writes(cyc);
    dispatch_v <= 1'b0;
    flush <= flush_now;
    prev_mul = 1'b0;
  endtask

  // Outputs settle after the rising edge, so compare at the falling edge
  always @(negedge clk)
    begin
      if (cyc > 0 && cyc < hist_els_lp)
        begin
          if (commit_v !== exp_c_v[cyc])
            begin
              errors++;
              if (exp_c_v[cyc])
                $display("expected commit did not appear in cycle %0d", cyc);
              else
                $display("commit appeared in cycle %0d with none expected", cyc);
            end
          else if (commit_v)
            begin
              if (commit_illegal !== exp_c_ill[cyc])
                begin
                  errors++;
                  $display("Fail commit_illegal_o cycle %0d: got %h expected %h",
                           cyc, commit_illegal, exp_c_ill[cyc]);
                end
              if (commit_instr !== exp_c_instr[cyc])
                begin
                  errors++;
                  $display("Fail commit_instr_o cycle %0d: got %h expected %h",
                           cyc, commit_instr, exp_c_instr[cyc]);
                end
            end
          if (wb_v !== exp_w_v[cyc])
            begin
              errors++;
              if (exp_w_v[cyc])
                $display("expected writeback did not appear in cycle %0d", cyc);
              else
                $display("writeback appeared in cycle %0d with none expected", cyc);
            end
          else if (wb_v)
            begin
              if (wb_rd_addr !== exp_w_rd[cyc])
                begin
                  errors++;
                  $display("Fail wb_rd_addr_o cycle %0d: got %h expected %h",
                           cyc, wb_rd_addr, exp_w_rd[cyc]);
                end
              if (wb_data !== exp_w_data[cyc])
                begin
                  errors++;
                  $display("Fail wb_data_o cycle %0d: got %h expected %h",
                           cyc, wb_data, exp_w_data[cyc]);
                end
            end
        end
    end

  task automatic reset_quiet();
    repeat (4) bubble(1'b0);
  endtask

  task automatic alu_ops();
    send(itype_word(12'hffb, 5'd0, 3'b000, 5'd1), 0, 0);
    send(itype_word(12'h007, 5'd0, 3'b000, 5'd2), 0, 0);
    repeat (5) bubble(1'b0);
    send(rtype_word(7'h00, 5'd2, 5'd1, 3'b000, 5'd3), 0, 0);
    send(rtype_word(7'h20, 5'd2, 5'd1, 3'b000, 5'd4), 0, 0);
    send(rtype_word(7'h00, 5'd2, 5'd1, 3'b010, 5'd5), 0, 0);
    send(rtype_word(7'h00, 5'd1, 5'd2, 3'b010, 5'd6), 0, 0);
    send(rtype_word(7'h00, 5'd2, 5'd2, 3'b001, 5'd7), 0, 0);
    send(rtype_word(7'h00, 5'd2, 5'd1, 3'b101, 5'd8), 0, 0);
    send(rtype_word(7'h00, 5'd2, 5'd1, 3'b100, 5'd9), 0, 0);
    send(rtype_word(7'h00, 5'd2, 5'd1, 3'b110, 5'd10), 0, 0);
    send(rtype_word(7'h00, 5'd2, 5'd1, 3'b111, 5'd11), 0, 0);
    send(itype_word(12'h800, 5'd1, 3'b010, 5'd12), 0, 0);
    send(itype_word(12'h0f0, 5'd1, 3'b100, 5'd13), 0, 0);
    send(itype_word(12'h70f, 5'd2, 3'b110, 5'd14), 0, 0);
    send(itype_word(12'hff0, 5'd1, 3'b111, 5'd15), 0, 0);
    // rd of x0 commits without a writeback
    send(rtype_word(7'h00, 5'd2, 5'd1, 3'b000, 5'd0), 0, 0);
    repeat (5) bubble(1'b0);
  endtask

  task automatic dependent_chain();
    send(itype_word(12'h011, 5'd0, 3'b000, 5'd16), 0, 0);
    for (int i = 0; i < 6; i++)
      send(itype_word(12'h003, 5'd16, 3'b000, 5'd16), 0, 0);
    send(rtype_word(7'h00, 5'd16, 5'd16, 3'b000, 5'd17), 0, 0);
    send(rtype_word(7'h20, 5'd16, 5'd17, 3'b000, 5'd18), 0, 0);
    send(rtype_word(7'h00, 5'd18, 5'd17, 3'b100, 5'd16), 0, 0);
    send(rtype_word(7'h00, 5'd16, 5'd18, 3'b001, 5'd19), 0, 0);
    // Producers three to five dispatches back
    send(rtype_word(7'h00, 5'd16, 5'd17, 3'b100, 5'd29), 0, 0);
    send(rtype_word(7'h00, 5'd17, 5'd18, 3'b110, 5'd30), 0, 0);
    send(rtype_word(7'h00, 5'd18, 5'd19, 3'b000, 5'd31), 0, 0);
    repeat (5) bubble(1'b0);
  endtask

  task automatic mul_products();
    send(itype_word(12'hffd, 5'd0, 3'b000, 5'd20), 0, 0);
    send(itype_word(12'h4d2, 5'd0, 3'b000, 5'd21), 0, 0);
    send(rtype_word(7'h01, 5'd21, 5'd20, 3'b000, 5'd22), 0, 0);
    bubble(1'b0);
    send(rtype_word(7'h00, 5'd20, 5'd22, 3'b000, 5'd23), 0, 0);
    send(rtype_word(7'h01, 5'd21, 5'd22, 3'b000, 5'd24), 0, 0);
    bubble(1'b0);
    bubble(1'b0);
    send(rtype_word(7'h01, 5'd20, 5'd24, 3'b000, 5'd25), 0, 0);
    repeat (6) bubble(1'b0);
  endtask

  task automatic flush_kill();
    send(itype_word(12'h021, 5'd0, 3'b000, 5'd26), 0, 0);
    send(itype_word(12'h005, 5'd26, 3'b000, 5'd26), 1, 0);
    send(rtype_word(7'h00, 5'd26, 5'd26, 3'b000, 5'd27), 1, 0);
    send(itype_word(12'h0ff, 5'd26, 3'b110, 5'd28), 1, 1);
    send(rtype_word(7'h00, 5'd26, 5'd26, 3'b000, 5'd27), 0, 0);
    send(rtype_word(7'h00, 5'd27, 5'd26, 3'b100, 5'd28), 0, 0);
    repeat (5) bubble(1'b0);
  endtask

  task automatic illegal_and_random();
    logic [31:0] r;
    logic [2:0]  f3;
    logic [31:0] w;
    send(rtype_word(7'h20, 5'd2, 5'd1, 3'b101, 5'd3), 0, 0);
    send(itype_word(12'h003, 5'd1, 3'b001, 5'd4), 0, 0);
    send(32'h0000_a083, 0, 0);
    send(rtype_word(7'h01, 5'd2, 5'd1, 3'b100, 5'd5), 0, 0);
    repeat (5) bubble(1'b0);
    for (int i = 0; i < 200; i++)
      begin
        r = lcg_next();
        if (prev_mul || r[31:29] == 3'b000)
          bubble(1'b0);
        case (r[3:0])
          4'd0, 4'd1, 4'd2, 4'd3, 4'd4, 4'd5, 4'd6, 4'd7:
            begin
              f3 = (r[2:0] == 3'd3) ? 3'b000 : r[2:0];
              w = rtype_word((r[3:0] == 4'd3) ? 7'h20 : 7'h00, {1'b0, r[15:12]},
                             {1'b0, r[11:8]}, f3, {1'b0, r[7:4]});
            end
          4'd8, 4'd9:
            w = rtype_word(7'h01, {1'b0, r[15:12]}, {1'b0, r[11:8]}, 3'b000, {1'b0, r[7:4]});
          4'd15:
            w = {r[31:7], 7'b0000011};
          default:
            begin
              f3 = (r[18:16] inside {3'b001, 3'b011, 3'b101}) ? 3'b000 : r[18:16];
              w = itype_word(r[28:17], {1'b0, r[11:8]}, f3, {1'b0, r[7:4]});
            end
        endcase
        send(w, 0, 0);
      end
    repeat (8) bubble(1'b0);
  endtask

  initial
    begin
      flush = 1'b0;
      dispatch_v = 1'b0;
      dispatch_instr = '0;
      dispatch_rs1 = '0;
      dispatch_rs2 = '0;
      cyc = 0;
      errors = 0;
      dispatched = 0;
      prev_mul = 1'b0;
      lcg_state = 32'h1dbb2738;
      for (int i = 0; i < 32; i++)
        begin
          arch_rf[i] = '0;
          stale_rf[i] = '0;
        end
      wait (reset === 1'b0);
      reset_quiet();
      alu_ops();
      dependent_chain();
      mul_products();
      flush_kill();
      illegal_and_random();
      $display("errors: %0d over %0d dispatched instructions", errors, dispatched);
      if (errors == 0)
        $display("=== PASS ===");
      else
        $display("=== FAIL ===");
      $finish;
    end

  initial
    begin
      #((planned_instr_lp + 20) * 10 * 20);
      $display("watchdog timeout, tests did not finish, errors so far: %0d", errors);
      $display("=== FAIL ===");
      $finish;
    end

endmodule

/* dv/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock
  (output logic clk_o
  , output logic reset_o
  );

  initial
    begin
      clk_o = 1'b0;
      forever #10 clk_o = ~clk_o;
    end

  // Reset held for three rising edges
  initial
    begin
      reset_o = 1'b1;
      repeat (3) @(posedge clk_o);
      reset_o <= 1'b0;
    end

endmodule

/* logic/calc_bypass.sv */
`timescale 1ns/1ps

module calc_bypass
  (input [calc_pkg::reg_addr_width_lp-1:0]                            rs1_addr_i
  , input [calc_pkg::reg_addr_width_lp-1:0]                           rs2_addr_i
  , input [calc_pkg::data_width_lp-1:0]                               rs1_i
  , input [calc_pkg::data_width_lp-1:0]                               rs2_i
  , input [calc_pkg::fwd_els_lp-1:0]                                  fwd_v_i
  , input [calc_pkg::fwd_els_lp-1:0][calc_pkg::reg_addr_width_lp-1:0] fwd_rd_addr_i
  , input [calc_pkg::fwd_els_lp-1:0][calc_pkg::data_width_lp-1:0]     fwd_data_i
  , output logic [calc_pkg::data_width_lp-1:0]                        bypass_rs1_o
  , output logic [calc_pkg::data_width_lp-1:0]                        bypass_rs2_o
  );

  import calc_pkg::*;

  logic [fwd_els_lp-1:0] rs1_hit, rs2_hit;

  always_comb
    begin
      bypass_rs1_o = rs1_i;
      bypass_rs2_o = rs2_i;
      // Oldest slice first, so the youngest match is applied last
      for (int i = fwd_els_lp-1; i >= 0; i--)
        begin
          rs1_hit[i] = fwd_v_i[i] & (fwd_rd_addr_i[i] == rs1_addr_i);
          rs2_hit[i] = fwd_v_i[i] & (fwd_rd_addr_i[i] == rs2_addr_i);
          if (rs1_hit[i])
            bypass_rs1_o = fwd_data_i[i];
          if (rs2_hit[i])
            bypass_rs2_o = fwd_data_i[i];
        end
      // x0 is hardwired
      if (rs1_addr_i == '0)
        bypass_rs1_o = '0;
      if (rs2_addr_i == '0)
        bypass_rs2_o = '0;
    end

  always_comb
    begin
      for (int i = 0; i < fwd_els_lp; i++)
        begin
          if (rs1_hit[i] | rs2_hit[i])
            assert (!$isunknown(fwd_data_i[i]))
              else $error("forward slice %0d matched with unknown data", i);
        end
    end

endmodule

/* logic/calc_completion.sv */
`timescale 1ns/1ps

module calc_completion
  (input                                       clk_i
  , input                                      reset_i
  , input                                      flush_i
  , input                                      ex1_v_i
  , input                                      ex1_int_v_i
  , input                                      ex1_mul_v_i
  , input                                      ex1_irf_w_v_i
  , input                                      ex1_illegal_i
  , input calc_pkg::calc_instr_u               ex1_instr_i
  , input [calc_pkg::data_width_lp-1:0]        int_data_i
  , input [calc_pkg::data_width_lp-1:0]        mul_data_i
  , output logic [calc_pkg::fwd_els_lp-1:0]    fwd_v_o
  , output logic [calc_pkg::fwd_els_lp-1:0][calc_pkg::reg_addr_width_lp-1:0] fwd_rd_addr_o
  , output logic [calc_pkg::fwd_els_lp-1:0][calc_pkg::data_width_lp-1:0]     fwd_data_o
  , output logic                               commit_v_o
  , output calc_pkg::calc_instr_u              commit_instr_o
  , output logic                               commit_illegal_o
  , output logic                               wb_v_o
  , output logic [calc_pkg::reg_addr_width_lp-1:0] wb_rd_addr_o
  , output logic [calc_pkg::data_width_lp-1:0]     wb_data_o
  );

  import calc_pkg::*;

  logic [pipe_stage_els_lp:0]   v_n, mul_v_n, irf_w_v_n, illegal_n, poison_n;
  logic [pipe_stage_els_lp-1:0] v_r, mul_v_r, irf_w_v_r, illegal_r, poison_r;

  calc_instr_u [pipe_stage_els_lp:0]   instr_n;
  calc_instr_u [pipe_stage_els_lp-1:0] instr_r;

  logic [pipe_stage_els_lp:0][data_width_lp-1:0]   comp_n;
  logic [pipe_stage_els_lp-1:0][data_width_lp-1:0] comp_r;

  logic                         wb_v_r;
  logic [reg_addr_width_lp-1:0] wb_rd_addr_r;
  logic [data_width_lp-1:0]     wb_data_r;

  // New entry at stage 0, everything else moves down
  assign v_n       = {v_r, ex1_v_i};
  assign mul_v_n   = {mul_v_r, ex1_mul_v_i};
  assign irf_w_v_n = {irf_w_v_r, ex1_irf_w_v_i};
  assign illegal_n = {illegal_r, ex1_illegal_i};
  assign instr_n   = {instr_r, ex1_instr_i};

  always_comb
    begin
      poison_n[0] = flush_i;
      comp_n[0]   = ex1_int_v_i ? int_data_i : '0;
      for (int i = 1; i <= pipe_stage_els_lp; i++)
        begin
          // Flush only reaches entries that have not committed
          poison_n[i] = poison_r[i-1] | (flush_i & (i <= commit_stage_lp));
          comp_n[i]   = ((i == mul_stage_lp) && mul_v_r[i-1]) ? mul_data_i : comp_r[i-1];
        end
    end

  always_ff @(posedge clk_i)
    begin
      if (reset_i)
        begin
          v_r      <= '0;
          poison_r <= '0;
          wb_v_r   <= 1'b0;
        end
      else
        begin
          v_r      <= v_n[pipe_stage_els_lp-1:0];
          poison_r <= poison_n[pipe_stage_els_lp-1:0];
          wb_v_r   <= wb_v_o;
        end
    end

  always_ff @(posedge clk_i)
    begin
      mul_v_r      <= mul_v_n[pipe_stage_els_lp-1:0];
      irf_w_v_r    <= irf_w_v_n[pipe_stage_els_lp-1:0];
      illegal_r    <= illegal_n[pipe_stage_els_lp-1:0];
      instr_r      <= instr_n[pipe_stage_els_lp-1:0];
      comp_r       <= comp_n[pipe_stage_els_lp-1:0];
      wb_rd_addr_r <= wb_rd_addr_o;
      wb_data_r    <= wb_data_o;
    end

  assign commit_v_o       = v_r[commit_stage_lp] & ~poison_r[commit_stage_lp];
  assign commit_instr_o   = instr_r[commit_stage_lp];
  assign commit_illegal_o = commit_v_o & illegal_r[commit_stage_lp];

  assign wb_v_o       = v_r[wb_stage_lp] & irf_w_v_r[wb_stage_lp] & ~poison_r[wb_stage_lp];
  assign wb_rd_addr_o = instr_r[wb_stage_lp].rtype.rd_addr;
  assign wb_data_o    = comp_r[wb_stage_lp];

  // Youngest slice at index 0, last writeback at the top
  always_comb
    begin
      for (int i = 0; i <= pipe_stage_els_lp; i++)
        begin
          fwd_v_o[i]       = v_n[i] & irf_w_v_n[i] & ~poison_n[i];
          fwd_rd_addr_o[i] = instr_n[i].rtype.rd_addr;
          fwd_data_o[i]    = comp_n[i];
        end
      fwd_v_o[fwd_els_lp-1]       = wb_v_r;
      fwd_rd_addr_o[fwd_els_lp-1] = wb_rd_addr_r;
      fwd_data_o[fwd_els_lp-1]    = wb_data_r;
    end

  a_int_mul_excl: assert property (@(posedge clk_i) disable iff (reset_i)
    (v_r[mul_stage_lp-1] & mul_v_r[mul_stage_lp-1]) |-> !$past(ex1_int_v_i));

  a_wb_rd_nonzero: assert property (@(posedge clk_i) disable iff (reset_i)
    wb_v_o |-> (wb_rd_addr_o != '0));

  // A flush in either cycle before commit must have poisoned the entry
  a_commit_unpoisoned: assert property (@(posedge clk_i) disable iff (reset_i)
    commit_v_o |-> (!$past(flush_i) && !$past(flush_i, 2)));

endmodule

/* logic/calc_decode.sv */
`timescale 1ns/1ps

module calc_decode
  (input calc_pkg::calc_instr_u                instr_i
  , output logic                               int_v_o
  , output logic                               mul_v_o
  , output logic                               use_imm_o
  , output logic                               irf_w_v_o
  , output logic                               illegal_o
  , output logic [calc_pkg::data_width_lp-1:0] imm_o
  );

  import calc_pkg::*;

  always_comb
    begin
      int_v_o   = 1'b0;
      mul_v_o   = 1'b0;
      use_imm_o = 1'b0;
      case (instr_i.rtype.opcode)
        opcode_op_lp:
          begin
            case (instr_i.rtype.funct7)
              7'b0000000:
                int_v_o = instr_i.rtype.funct3 inside {funct3_add_lp, funct3_sll_lp,
                  funct3_slt_lp, funct3_xor_lp, funct3_srl_lp, funct3_or_lp, funct3_and_lp};
              // SUB only, no arithmetic shift
              funct7_alt_lp:    int_v_o = (instr_i.rtype.funct3 == funct3_add_lp);
              funct7_muldiv_lp: mul_v_o = (instr_i.rtype.funct3 == funct3_mul_lp);
              default:          int_v_o = 1'b0;
            endcase
          end
        opcode_op_imm_lp:
          begin
            use_imm_o = 1'b1;
            int_v_o   = instr_i.itype.funct3 inside {funct3_add_lp, funct3_slt_lp,
              funct3_xor_lp, funct3_or_lp, funct3_and_lp};
          end
        default: use_imm_o = 1'b0;
      endcase
    end

  // Anything that reaches neither pipe is illegal
  assign illegal_o = ~(int_v_o | mul_v_o);
  assign irf_w_v_o = ~illegal_o & (instr_i.itype.rd_addr != '0);

  assign imm_o = {{(data_width_lp-imm_width_lp){instr_i.itype.imm12[imm_width_lp-1]}}
                 , instr_i.itype.imm12};

endmodule

/* logic/calc_pipe_int.sv */
`timescale 1ns/1ps

module calc_pipe_int
  (input calc_pkg::calc_instr_u                instr_i
  , input                                      use_imm_i
  , input [calc_pkg::data_width_lp-1:0]        rs1_i
  , input [calc_pkg::data_width_lp-1:0]        rs2_i
  , input [calc_pkg::data_width_lp-1:0]        imm_i
  , output logic [calc_pkg::data_width_lp-1:0] data_o
  );

  import calc_pkg::*;

  logic [data_width_lp-1:0]  src2;
  logic [shamt_width_lp-1:0] shamt;
  logic                      sub_v;

  assign src2  = use_imm_i ? imm_i : rs2_i;
  assign shamt = src2[shamt_width_lp-1:0];

  // funct7 overlaps the immediate in I-type words
  assign sub_v = ~use_imm_i & (instr_i.rtype.funct7 == funct7_alt_lp);

  always_comb
    begin
      case (instr_i.rtype.funct3)
        funct3_add_lp: data_o = sub_v ? (rs1_i - src2) : (rs1_i + src2);
        funct3_sll_lp: data_o = rs1_i << shamt;
        funct3_slt_lp: data_o = {{(data_width_lp-1){1'b0}}, ($signed(rs1_i) < $signed(src2))};
        funct3_xor_lp: data_o = rs1_i ^ src2;
        funct3_srl_lp: data_o = rs1_i >> shamt;
        funct3_or_lp:  data_o = rs1_i | src2;
        funct3_and_lp: data_o = rs1_i & src2;
        default:       data_o = '0;
      endcase
    end

endmodule

/* logic/calc_pipe_mul.sv */
`timescale 1ns/1ps

module calc_pipe_mul
  (input                                       clk_i
  , input [calc_pkg::data_width_lp-1:0]        rs1_i
  , input [calc_pkg::data_width_lp-1:0]        rs2_i
  , output logic [calc_pkg::data_width_lp-1:0] data_o
  );

  import calc_pkg::*;

  logic [data_width_lp-1:0] prod_lo;
  logic [data_width_lp-1:0] prod_r;

  // Low half is the same for signed and unsigned operands
  assign prod_lo = rs1_i * rs2_i;

  // EX1 product lands here, lined up with the mul completion stage
  always_ff @(posedge clk_i)
    begin
      prod_r <= prod_lo;
    end

  assign data_o = prod_r;

endmodule

/* logic/calc_pkg.sv */
package calc_pkg;

  localparam data_width_lp     = 32;
  localparam reg_addr_width_lp = 5;
  localparam instr_width_lp    = 32;
  localparam shamt_width_lp    = 5;

  // I-type immediate sits above rs1, funct3, rd and opcode
  localparam imm_width_lp = instr_width_lp - 20;

  // Stage registers behind the reservation register
  localparam pipe_stage_els_lp = 3;
  localparam commit_stage_lp   = 1;
  localparam wb_stage_lp       = 2;
  localparam mul_stage_lp      = 1;

  // Next-state stages plus the last writeback
  localparam fwd_els_lp = pipe_stage_els_lp + 2;

  localparam logic [6:0] opcode_op_lp     = 7'b0110011;
  localparam logic [6:0] opcode_op_imm_lp = 7'b0010011;

  localparam logic [2:0] funct3_add_lp = 3'b000;
  localparam logic [2:0] funct3_sll_lp = 3'b001;
  localparam logic [2:0] funct3_slt_lp = 3'b010;
  localparam logic [2:0] funct3_xor_lp = 3'b100;
  localparam logic [2:0] funct3_srl_lp = 3'b101;
  localparam logic [2:0] funct3_or_lp  = 3'b110;
  localparam logic [2:0] funct3_and_lp = 3'b111;
  localparam logic [2:0] funct3_mul_lp = 3'b000;

  localparam logic [6:0] funct7_alt_lp    = 7'b0100000;
  localparam logic [6:0] funct7_muldiv_lp = 7'b0000001;

  typedef union packed
  {
    struct packed
    {
      logic [6:0]                   funct7;
      logic [reg_addr_width_lp-1:0] rs2_addr;
      logic [reg_addr_width_lp-1:0] rs1_addr;
      logic [2:0]                   funct3;
      logic [reg_addr_width_lp-1:0] rd_addr;
      logic [6:0]                   opcode;
    } rtype;
    struct packed
    {
      logic [imm_width_lp-1:0]      imm12;
      logic [reg_addr_width_lp-1:0] rs1_addr;
      logic [2:0]                   funct3;
      logic [reg_addr_width_lp-1:0] rd_addr;
      logic [6:0]                   opcode;
    } itype;
  } calc_instr_u;

endpackage

/* logic/calculator_top.sv */
`timescale 1ns/1ps

module calculator_top
  (input                                           clk_i
  , input                                          reset_i
  , input                                          flush_i
  , input                                          dispatch_v_i
  , input calc_pkg::calc_instr_u                   dispatch_instr_i
  , input [calc_pkg::data_width_lp-1:0]            dispatch_rs1_i
  , input [calc_pkg::data_width_lp-1:0]            dispatch_rs2_i
  , output logic                                   commit_v_o
  , output calc_pkg::calc_instr_u                  commit_instr_o
  , output logic                                   commit_illegal_o
  , output logic                                   wb_v_o
  , output logic [calc_pkg::reg_addr_width_lp-1:0] wb_rd_addr_o
  , output logic [calc_pkg::data_width_lp-1:0]     wb_data_o
  );

  import calc_pkg::*;

  logic                     dec_int_v, dec_mul_v, dec_use_imm, dec_irf_w_v, dec_illegal;
  logic [data_width_lp-1:0] dec_imm;
  logic [data_width_lp-1:0] bypass_rs1, bypass_rs2;

  logic [fwd_els_lp-1:0]                        fwd_v;
  logic [fwd_els_lp-1:0][reg_addr_width_lp-1:0] fwd_rd_addr;
  logic [fwd_els_lp-1:0][data_width_lp-1:0]     fwd_data;

  logic                     res_v_r, res_int_v_r, res_mul_v_r, res_use_imm_r;
  logic                     res_irf_w_v_r, res_illegal_r;
  logic [data_width_lp-1:0] res_imm_r, res_rs1_r, res_rs2_r;
  calc_instr_u              res_instr_r;

  logic [data_width_lp-1:0] int_data, mul_data;

  calc_decode decode
    (.instr_i(dispatch_instr_i)
    ,.int_v_o(dec_int_v)
    ,.mul_v_o(dec_mul_v)
    ,.use_imm_o(dec_use_imm)
    ,.irf_w_v_o(dec_irf_w_v)
    ,.illegal_o(dec_illegal)
    ,.imm_o(dec_imm)
    );

  calc_bypass bypass
    (.rs1_addr_i(dispatch_instr_i.rtype.rs1_addr)
    ,.rs2_addr_i(dispatch_instr_i.rtype.rs2_addr)
    ,.rs1_i(dispatch_rs1_i)
    ,.rs2_i(dispatch_rs2_i)
    ,.fwd_v_i(fwd_v)
    ,.fwd_rd_addr_i(fwd_rd_addr)
    ,.fwd_data_i(fwd_data)
    ,.bypass_rs1_o(bypass_rs1)
    ,.bypass_rs2_o(bypass_rs2)
    );

  // A flush on the dispatch edge drops the instruction here
  always_ff @(posedge clk_i)
    begin
      if (reset_i)
        res_v_r <= 1'b0;
      else
        res_v_r <= dispatch_v_i & ~flush_i;
    end

  always_ff @(posedge clk_i)
    begin
      res_int_v_r   <= dec_int_v;
      res_mul_v_r   <= dec_mul_v;
      res_use_imm_r <= dec_use_imm;
      res_irf_w_v_r <= dec_irf_w_v;
      res_illegal_r <= dec_illegal;
      res_imm_r     <= dec_imm;
      res_rs1_r     <= bypass_rs1;
      res_rs2_r     <= bypass_rs2;
      res_instr_r   <= dispatch_instr_i;
    end

  calc_pipe_int pipe_int
    (.instr_i(res_instr_r)
    ,.use_imm_i(res_use_imm_r)
    ,.rs1_i(res_rs1_r)
    ,.rs2_i(res_rs2_r)
    ,.imm_i(res_imm_r)
    ,.data_o(int_data)
    );

  calc_pipe_mul pipe_mul
    (.clk_i(clk_i)
    ,.rs1_i(res_rs1_r)
    ,.rs2_i(res_rs2_r)
    ,.data_o(mul_data)
    );

  calc_completion completion
    (.clk_i(clk_i)
    ,.reset_i(reset_i)
    ,.flush_i(flush_i)
    ,.ex1_v_i(res_v_r)
    ,.ex1_int_v_i(res_int_v_r)
    ,.ex1_mul_v_i(res_mul_v_r)
    ,.ex1_irf_w_v_i(res_irf_w_v_r)
    ,.ex1_illegal_i(res_illegal_r)
    ,.ex1_instr_i(res_instr_r)
    ,.int_data_i(int_data)
    ,.mul_data_i(mul_data)
    ,.fwd_v_o(fwd_v)
    ,.fwd_rd_addr_o(fwd_rd_addr)
    ,.fwd_data_o(fwd_data)
    ,.commit_v_o(commit_v_o)
    ,.commit_instr_o(commit_instr_o)
    ,.commit_illegal_o(commit_illegal_o)
    ,.wb_v_o(wb_v_o)
    ,.wb_rd_addr_o(wb_rd_addr_o)
    ,.wb_data_o(wb_data_o)
    );

endmodule
